//--- all.f
+incdir+.
cacheDataPkg.sv
cacheCtrlPkg.sv
dcacheWays.sv
dcacheVictim.sv
dcacheCtrl.sv
dcache.sv
dcacheTb.sv

//--- cacheCtrlPkg.sv
`default_nettype none

package cacheCtrlPkg;

	typedef enum logic [3:0] {
		Idle,
		ReadHit,
		Overwrite,
		WriteHit,
		CleanA,
		CleanB,
		FillA,
		FillB,
		Flush,
		Stop
	} ctrlStateT;

	// Strobes from the controller to the way storage
	typedef struct packed {
		logic fill;
		logic fillWord;
		logic merge;
		logic clean;
		logic touch;
	} wayCmdT;

	// Victim or flush target chosen for the current index
	typedef struct packed {
		logic                way;
		logic                dirty;
		cacheDataPkg::wordT  wbAddr;
		cacheDataPkg::blockT wbBlock;
	} victimT;

endpackage

`default_nettype wire

//--- cacheDataPkg.sv
`default_nettype none

`include "dcache_cfg.svh"

package cacheDataPkg;

	typedef logic [`DCACHE_WORD_BITS-1:0] wordT;
	typedef logic [`DCACHE_TAG_BITS-1:0] tagT;
	typedef logic [`DCACHE_IDX_BITS-1:0] idxT;

	// Byte address as seen by the cache
	typedef struct packed {
		tagT        tag;
		idxT        idx;
		logic       blkOff;
		logic [1:0] byteOff;
	} dAddrT;

	typedef struct packed {
		wordT wordA;
		wordT wordB;
	} blockT;

	// Only the tag is kept, index is implied by the slot
	typedef struct packed {
		tagT   tag;
		blockT block;
		logic  valid;
		logic  dirty;
	} frameT;

	typedef struct packed {
		logic read;
		logic write;
		wordT addr;
		wordT store;
	} cpuReqT;

	typedef struct packed {
		logic ren;
		logic wen;
		wordT addr;
		wordT store;
	} memReqT;

	// Both frames at one index plus its LRU bit
	typedef struct packed {
		frameT [1:0] frame;
		logic        lru;
	} setViewT;

	// One dirty bit per frame, indexed [way][set]
	typedef logic [1:0][`DCACHE_SETS-1:0] dirtyVecT;

endpackage

`default_nettype wire

//--- dcache.sv
`default_nettype none
`timescale 1ns/1ps

module dcache (
	input  logic                 CLK,
	input  logic                 nRST,
	input  logic                 halt,
	input  cacheDataPkg::cpuReqT cpuReq,
	output logic                 dhit,
	output cacheDataPkg::wordT   dmemLoad,
	output logic                 flushed,
	output cacheDataPkg::memReqT memReq,
	input  cacheDataPkg::wordT   dload,
	input  logic                 dwait
);

	cacheDataPkg::dAddrT    reqAddr;
	logic                   req;
	cacheDataPkg::idxT      idx;
	cacheCtrlPkg::wayCmdT   wayCmd;
	cacheCtrlPkg::victimT   victim;
	cacheDataPkg::setViewT  setView;
	cacheDataPkg::dirtyVecT dirtyVec;
	logic                   hit;
	cacheDataPkg::wordT     hitWord;
	logic                   flushAny;
	cacheDataPkg::wordT     fillAddrA;
	cacheDataPkg::wordT     fillAddrB;

	assign reqAddr = cacheDataPkg::dAddrT'(cpuReq.addr);
	assign req     = cpuReq.read || cpuReq.write;

	dcacheCtrl ctrl_inst (
		.CLK(CLK), .nRST(nRST), .halt(halt), .cpuReq(cpuReq),
		.hit(hit), .hitWord(hitWord), .victim(victim), .flushAny(flushAny),
		.fillAddrA(fillAddrA), .fillAddrB(fillAddrB), .dload(dload), .dwait(dwait),
		.wayCmd(wayCmd), .memReq(memReq), .dhit(dhit), .dmemLoad(dmemLoad),
		.flushed(flushed)
	);

	dcacheWays ways_inst (
		.CLK(CLK), .nRST(nRST), .idx(idx), .tag(reqAddr.tag), .blkOff(reqAddr.blkOff),
		.req(req), .victimWay(victim.way), .wayCmd(wayCmd), .dload(dload),
		.dwait(dwait), .store(cpuReq.store), .hit(hit), .hitWay(),
		.hitWord(hitWord), .setView(setView), .dirtyVec(dirtyVec)
	);

	dcacheVictim victim_inst (
		.halt(halt), .reqAddr(reqAddr), .setView(setView), .dirtyVec(dirtyVec),
		.idx(idx), .victim(victim), .flushAny(flushAny),
		.fillAddrA(fillAddrA), .fillAddrB(fillAddrB)
	);

endmodule

`default_nettype wire

//--- dcacheCtrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcacheCtrl (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  halt,
	input  cacheDataPkg::cpuReqT  cpuReq,
	input  logic                  hit,
	input  cacheDataPkg::wordT    hitWord,
	input  cacheCtrlPkg::victimT  victim,
	input  logic                  flushAny,
	input  cacheDataPkg::wordT    fillAddrA,
	input  cacheDataPkg::wordT    fillAddrB,
	input  cacheDataPkg::wordT    dload,
	input  logic                  dwait,
	output cacheCtrlPkg::wayCmdT  wayCmd,
	output cacheDataPkg::memReqT  memReq,
	output logic                  dhit,
	output cacheDataPkg::wordT    dmemLoad,
	output logic                  flushed
);

	cacheCtrlPkg::ctrlStateT state;
	cacheCtrlPkg::ctrlStateT nextState;
	logic                    req;

	assign req = cpuReq.read || cpuReq.write;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= cacheCtrlPkg::Idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		unique case (state)
			cacheCtrlPkg::Idle: begin
				if (halt) begin
					nextState = cacheCtrlPkg::Flush;
				end else if (req && hit) begin
					nextState = cpuReq.read ? cacheCtrlPkg::ReadHit : cacheCtrlPkg::Overwrite;
				end else if (req) begin
					// Miss, write back first if the victim is dirty
					nextState = victim.dirty ? cacheCtrlPkg::CleanA : cacheCtrlPkg::FillA;
				end
			end
			cacheCtrlPkg::ReadHit:   nextState = cacheCtrlPkg::Idle;
			cacheCtrlPkg::Overwrite: nextState = cacheCtrlPkg::WriteHit;
			cacheCtrlPkg::WriteHit:  nextState = cacheCtrlPkg::Idle;
			cacheCtrlPkg::CleanA: begin
				if (!dwait) nextState = cacheCtrlPkg::CleanB;
			end
			cacheCtrlPkg::CleanB: begin
				if (!dwait) nextState = halt ? cacheCtrlPkg::Flush : cacheCtrlPkg::FillA;
			end
			cacheCtrlPkg::FillA: begin
				if (!dwait) nextState = cacheCtrlPkg::FillB;
			end
			cacheCtrlPkg::FillB: begin
				// Reads re-enter Idle and then hit
				if (!dwait) nextState = cpuReq.write ? cacheCtrlPkg::Overwrite : cacheCtrlPkg::Idle;
			end
			cacheCtrlPkg::Flush: nextState = flushAny ? cacheCtrlPkg::CleanA : cacheCtrlPkg::Stop;
			cacheCtrlPkg::Stop:  nextState = cacheCtrlPkg::Stop;
			default:             nextState = cacheCtrlPkg::Idle;
		endcase
	end

	always_comb begin
		wayCmd   = '0;
		memReq   = '0;
		dhit     = 1'b0;
		dmemLoad = '0;
		flushed  = 1'b0;
		case (state)
			cacheCtrlPkg::ReadHit: begin
				dhit         = 1'b1;
				dmemLoad     = hitWord;
				wayCmd.touch = 1'b1;
			end
			cacheCtrlPkg::Overwrite: wayCmd.merge = 1'b1;
			cacheCtrlPkg::WriteHit: begin
				dhit         = 1'b1;
				wayCmd.touch = 1'b1;
			end
			cacheCtrlPkg::CleanA: begin
				memReq.wen   = 1'b1;
				memReq.addr  = victim.wbAddr;
				memReq.store = victim.wbBlock.wordA;
			end
			cacheCtrlPkg::CleanB: begin
				// Dirty clears only here so the flush target holds for both words
				memReq.wen   = 1'b1;
				memReq.addr  = victim.wbAddr + `DCACHE_WORD_BYTES;
				memReq.store = victim.wbBlock.wordB;
				wayCmd.clean = 1'b1;
			end
			cacheCtrlPkg::FillA: begin
				memReq.ren  = 1'b1;
				memReq.addr = fillAddrA;
				wayCmd.fill = 1'b1;
			end
			cacheCtrlPkg::FillB: begin
				memReq.ren      = 1'b1;
				memReq.addr     = fillAddrB;
				wayCmd.fill     = 1'b1;
				wayCmd.fillWord = 1'b1;
			end
			cacheCtrlPkg::Stop: flushed = 1'b1;
			default: ;
		endcase
	end

	assert property (@(posedge CLK) disable iff (!nRST || !`DCACHE_ASSERT_ON)
		!(memReq.ren && memReq.wen))
		else $error("dcacheCtrl: ren and wen both high");

	// Bus request must hold while memory stalls
	assert property (@(posedge CLK) disable iff (!nRST || !`DCACHE_ASSERT_ON)
		(memReq.ren || memReq.wen) && dwait |=> $stable(memReq))
		else $error("dcacheCtrl: memReq changed during dwait");

	assert property (@(posedge CLK) disable iff (!nRST || !`DCACHE_ASSERT_ON)
		dhit |-> req)
		else $error("dcacheCtrl: dhit without a request");

	// Fill data taken from the bus must be known
	assert property (@(posedge CLK) disable iff (!nRST || !`DCACHE_ASSERT_ON)
		memReq.ren && !dwait |-> !$isunknown(dload))
		else $error("dcacheCtrl: unknown dload on completed read");

endmodule

`default_nettype wire

//--- dcacheTb.sv
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcacheTb;

	logic                 CLK = 1'b0;
	logic                 nRST;
	logic                 halt;
	cacheDataPkg::cpuReqT cpuReq;
	logic                 dhit;
	cacheDataPkg::wordT   dmemLoad;
	logic                 flushed;
	cacheDataPkg::memReqT memReq;
	cacheDataPkg::wordT   dload;
	logic                 dwait;

	// Memory model contents and last processor writes by byte address
	cacheDataPkg::wordT mem    [cacheDataPkg::wordT];
	cacheDataPkg::wordT shadow [cacheDataPkg::wordT];

	logic [15:0]        lfsr = 16'd50;
	int                 waitLeft;
	int                 rdCount;
	cacheDataPkg::wordT lastWbAddr;
	cacheDataPkg::wordT expLoad;
	logic               expectHit;
	logic               started;
	int                 errCnt;
	int                 testsPassed;
	int                 testsFailed;

	dcache dcache_inst (
		.CLK(CLK), .nRST(nRST), .halt(halt), .cpuReq(cpuReq), .dhit(dhit),
		.dmemLoad(dmemLoad), .flushed(flushed), .memReq(memReq), .dload(dload),
		.dwait(dwait)
	);

	always #20 CLK = ~CLK;

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
	endtask

	function automatic cacheDataPkg::wordT initWord(input cacheDataPkg::wordT a);
		return {a[15:0] ^ 16'hC3A5, a[31:16]} + a;
	endfunction

	function automatic cacheDataPkg::wordT expectedAt(input cacheDataPkg::wordT a);
		return shadow.exists(a) ? shadow[a] : initWord(a);
	endfunction

	function automatic cacheDataPkg::wordT memAt(input cacheDataPkg::wordT a);
		return mem.exists(a) ? mem[a] : initWord(a);
	endfunction

	task automatic logFailure(input string msg);
		errCnt++;
		$display("%s", msg);
	endtask

	task automatic finishTest(input string name, input int errBefore);
		if (errCnt == errBefore) begin
			testsPassed++;
			$display("Test %s: passed", name);
		end else begin
			testsFailed++;
			$display("Test %s: failed with %0d errors", name, errCnt - errBefore);
		end
	endtask

	// Memory model where each access stalls 0 to 3 cycles
	always @(negedge CLK) begin
		logic [31:0] r;
		dload = '0;
		dwait = 1'b1;
		if (nRST && (memReq.ren || memReq.wen)) begin
			if (waitLeft > 0) begin
				waitLeft--;
			end else begin
				dwait = 1'b0;
				if (memReq.ren) begin
					dload = memAt(memReq.addr);
					rdCount++;
				end else begin
					assert (memReq.store == expectedAt(memReq.addr))
						else logFailure($sformatf("CHECK FAILED memReq.store addr=%h got=%h exp=%h",
							memReq.addr, memReq.store, expectedAt(memReq.addr)));
					mem[memReq.addr] = memReq.store;
					lastWbAddr       = memReq.addr;
				end
				drawBits(2, r);
				waitLeft = r;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (!nRST)
		!started |-> !dhit && !flushed && !memReq.ren && !memReq.wen)
		else logFailure($sformatf("CHECK FAILED idle outputs dhit=%h flushed=%h ren=%h wen=%h",
			$sampled(dhit), $sampled(flushed), $sampled(memReq.ren), $sampled(memReq.wen)));

	assert property (@(posedge CLK) disable iff (!nRST)
		dhit && cpuReq.read |-> dmemLoad == expLoad)
		else logFailure($sformatf("CHECK FAILED dmemLoad got=%h exp=%h",
			$sampled(dmemLoad), $sampled(expLoad)));

	// Fill reads stay inside the requested block with the base word first
	assert property (@(posedge CLK) disable iff (!nRST)
		memReq.ren |-> memReq.addr[31:3] == cpuReq.addr[31:3] && memReq.addr[1:0] == 2'b00)
		else logFailure($sformatf("CHECK FAILED memReq.addr got=%h exp=%h",
			$sampled(memReq.addr), {$sampled(cpuReq.addr[31:3]), 3'b000}));

	assert property (@(posedge CLK) disable iff (!nRST)
		memReq.ren && !memReq.addr[2] && !dwait |=>
		memReq.ren && memReq.addr == {cpuReq.addr[31:3], 3'b000} + `DCACHE_WORD_BYTES)
		else logFailure($sformatf("CHECK FAILED memReq.addr got=%h exp=%h",
			$sampled(memReq.addr),
			{$sampled(cpuReq.addr[31:3]), 3'b000} + `DCACHE_WORD_BYTES));

	assert property (@(posedge CLK) disable iff (!nRST)
		expectHit |-> !memReq.ren && !memReq.wen)
		else logFailure($sformatf("CHECK FAILED memReq on hit ren=%h wen=%h",
			$sampled(memReq.ren), $sampled(memReq.wen)));

	// Once flushed, the cache stays quiet
	assert property (@(posedge CLK) disable iff (!nRST)
		flushed |-> !memReq.ren && !memReq.wen ##1 flushed)
		else logFailure($sformatf("CHECK FAILED flushed=%h ren=%h wen=%h",
			$sampled(flushed), $sampled(memReq.ren), $sampled(memReq.wen)));

	task automatic access(input logic wr, input cacheDataPkg::wordT addr,
		input cacheDataPkg::wordT data, input logic hitExp);
		int n;
		n = 0;
		if (wr) shadow[addr] = data;
		expLoad      = expectedAt(addr);
		expectHit    = hitExp;
		started      = 1'b1;
		cpuReq.read  = !wr;
		cpuReq.write = wr;
		cpuReq.addr  = addr;
		cpuReq.store = wr ? data : '0;
		do begin
			@(negedge CLK);
			n++;
		end while (!dhit && n < 200);
		if (!dhit) begin
			logFailure($sformatf("Timed out waiting for dhit on address %h", addr));
		end else if (hitExp) begin
			assert (n == (wr ? 2 : 1))
				else logFailure($sformatf("CHECK FAILED dhit latency got=%h exp=%h", n, wr ? 2 : 1));
		end
		// Request held through the dhit edge
		@(negedge CLK);
		cpuReq    = '0;
		expectHit = 1'b0;
	endtask

	initial begin
		cacheDataPkg::wordT a;
		cacheDataPkg::wordT b;
		cacheDataPkg::wordT c;
		cacheDataPkg::wordT d;
		logic [31:0]        r;
		int                 e;
		int                 rd0;
		int                 cnt;
		nRST       = 1'b0;
		halt       = 1'b0;
		cpuReq     = '0;
		dload      = '0;
		dwait      = 1'b1;
		waitLeft   = 0;
		rdCount    = 0;
		lastWbAddr = '0;
		expLoad    = '0;
		expectHit  = 1'b0;
		started    = 1'b0;
		errCnt     = 0;
		repeat (5) @(negedge CLK);
		nRST = 1'b1;

		e = errCnt;
		repeat (4) @(negedge CLK);
		finishTest("reset", e);

		e   = errCnt;
		a   = 32'h0000_1008;
		rd0 = rdCount;
		access(1'b0, a, '0, 1'b0);
		assert (rdCount - rd0 == 2)
			else logFailure($sformatf("CHECK FAILED bus read count got=%h exp=%h", rdCount - rd0, 2));
		finishTest("read miss", e);

		e = errCnt;
		access(1'b0, a ^ 32'h4, '0, 1'b1);
		access(1'b1, a, 32'h1357_9BDF, 1'b1);
		access(1'b0, a, '0, 1'b1);
		finishTest("hit latency", e);

		// Three tags in set 2
		e = errCnt;
		a = 32'h0000_2010;
		b = 32'h0000_2050;
		c = 32'h0000_2094;
		access(1'b1, a, 32'h0A0A_0001, 1'b0);
		access(1'b1, b, 32'h0B0B_0002, 1'b0);
		access(1'b0, a, '0, 1'b1);
		access(1'b1, c, 32'h0C0C_0003, 1'b0);
		assert (lastWbAddr == {b[31:3], 3'b100})
			else logFailure($sformatf("CHECK FAILED lastWbAddr got=%h exp=%h",
				lastWbAddr, {b[31:3], 3'b100}));
		access(1'b0, a, '0, 1'b1);
		access(1'b0, b, '0, 1'b0);
		finishTest("LRU eviction", e);

		e = errCnt;
		for (int i = 0; i < 48; i++) begin
			drawBits(6, r);
			a = 32'h0000_4000 + {r[5:0], 2'b00};
			drawBits(1, r);
			if (r[0]) begin
				drawBits(32, d);
				access(1'b1, a, d, 1'b0);
				access(1'b0, a, '0, 1'b1);
			end else begin
				access(1'b0, a, '0, 1'b0);
			end
		end
		finishTest("random read after write", e);

		e    = errCnt;
		halt = 1'b1;
		cnt  = 0;
		while (!flushed && cnt < 2000) begin
			@(negedge CLK);
			cnt++;
		end
		if (!flushed) logFailure("Timed out waiting for flushed after halt");
		repeat (8) @(negedge CLK);
		foreach (shadow[k]) begin
			assert (memAt(k) == shadow[k])
				else logFailure($sformatf("CHECK FAILED mem[%h] got=%h exp=%h",
					k, memAt(k), shadow[k]));
		end
		finishTest("flush", e);

		$display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
		if (errCnt == 0 && testsFailed == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dcacheVictim.sv
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcacheVictim (
	input  logic                   halt,
	input  cacheDataPkg::dAddrT    reqAddr,
	input  cacheDataPkg::setViewT  setView,
	input  cacheDataPkg::dirtyVecT dirtyVec,
	output cacheDataPkg::idxT      idx,
	output cacheCtrlPkg::victimT   victim,
	output logic                   flushAny,
	output cacheDataPkg::wordT     fillAddrA,
	output cacheDataPkg::wordT     fillAddrB
);

	logic                flushWay;
	cacheDataPkg::idxT   flushIdx;
	logic                selWay;
	cacheDataPkg::dAddrT wbBase;
	cacheDataPkg::dAddrT fillBase;

	// Lowest index in way 0 wins, then way 1; scan runs backwards so the last hit sticks
	always_comb begin
		flushWay = 1'b0;
		flushIdx = '0;
		for (int w = 1; w >= 0; w--) begin
			for (int s = `DCACHE_SETS - 1; s >= 0; s--) begin
				if (dirtyVec[w][s]) begin
					flushWay = (w == 1);
					flushIdx = cacheDataPkg::idxT'(s);
				end
			end
		end
	end

	assign flushAny = |dirtyVec;
	assign idx      = halt ? flushIdx : reqAddr.idx;

	// Empty way first, otherwise the one not used last
	always_comb begin
		if (halt) begin
			selWay = flushWay;
		end else if (!setView.frame[0].valid) begin
			selWay = 1'b0;
		end else if (!setView.frame[1].valid) begin
			selWay = 1'b1;
		end else begin
			selWay = ~setView.lru;
		end
	end

	always_comb begin
		wbBase         = '0;
		wbBase.tag     = setView.frame[selWay].tag;
		wbBase.idx     = idx;
		victim.way     = selWay;
		victim.dirty   = setView.frame[selWay].dirty;
		victim.wbAddr  = cacheDataPkg::wordT'(wbBase);
		victim.wbBlock = setView.frame[selWay].block;
	end

	// Block base of the request
	always_comb begin
		fillBase         = reqAddr;
		fillBase.blkOff  = 1'b0;
		fillBase.byteOff = '0;
	end

	assign fillAddrA = cacheDataPkg::wordT'(fillBase);
	assign fillAddrB = cacheDataPkg::wordT'(fillBase) + `DCACHE_WORD_BYTES;

endmodule

`default_nettype wire

//--- dcacheWays.sv
`default_nettype none
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcacheWays (
	input  logic                   CLK,
	input  logic                   nRST,
	input  cacheDataPkg::idxT      idx,
	input  cacheDataPkg::tagT      tag,
	input  logic                   blkOff,
	input  logic                   req,
	input  logic                   victimWay,
	input  cacheCtrlPkg::wayCmdT   wayCmd,
	input  cacheDataPkg::wordT     dload,
	input  logic                   dwait,
	input  cacheDataPkg::wordT     store,
	output logic                   hit,
	output logic                   hitWay,
	output cacheDataPkg::wordT     hitWord,
	output cacheDataPkg::setViewT  setView,
	output cacheDataPkg::dirtyVecT dirtyVec
);

	// Payload storage
	cacheDataPkg::tagT   tagMem  [2][`DCACHE_SETS];
	cacheDataPkg::blockT dataMem [2][`DCACHE_SETS];

	// Per-frame state
	cacheDataPkg::dirtyVecT validQ;
	cacheDataPkg::dirtyVecT dirtyQ;
	logic [`DCACHE_SETS-1:0] lruQ;

	logic [1:0]          match;
	cacheDataPkg::blockT hitBlock;

	// Tag compare in both ways
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			match[w] = req && validQ[w][idx] && (tagMem[w][idx] == tag);
		end
	end

	assign hit      = |match;
	assign hitWay   = match[1];
	assign hitBlock = dataMem[hitWay][idx];
	assign hitWord  = blkOff ? hitBlock.wordB : hitBlock.wordA;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			setView.frame[w].tag   = tagMem[w][idx];
			setView.frame[w].block = dataMem[w][idx];
			setView.frame[w].valid = validQ[w][idx];
			setView.frame[w].dirty = dirtyQ[w][idx];
		end
		setView.lru = lruQ[idx];
	end

	assign dirtyVec = dirtyQ;

	// Data and tags, fill goes to the victim and merge to the hit way
	always_ff @(posedge CLK) begin
		if (wayCmd.fill && !dwait) begin
			if (wayCmd.fillWord) begin
				dataMem[victimWay][idx].wordB <= dload;
				tagMem[victimWay][idx]        <= tag;
			end else begin
				dataMem[victimWay][idx].wordA <= dload;
			end
		end else if (wayCmd.merge) begin
			if (blkOff) begin
				dataMem[hitWay][idx].wordB <= store;
			end else begin
				dataMem[hitWay][idx].wordA <= store;
			end
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			validQ <= '0;
			dirtyQ <= '0;
			lruQ   <= '0;
		end else begin
			// Block becomes valid once the second word lands
			if (wayCmd.fill && wayCmd.fillWord && !dwait) begin
				validQ[victimWay][idx] <= 1'b1;
				dirtyQ[victimWay][idx] <= 1'b0;
			end
			if (wayCmd.merge) begin
				dirtyQ[hitWay][idx] <= 1'b1;
			end
			if (wayCmd.clean && !dwait) begin
				dirtyQ[victimWay][idx] <= 1'b0;
			end
			if (wayCmd.touch) begin
				lruQ[idx] <= hitWay;
			end
		end
	end

	// A fill only ever targets a missing tag, so both ways never match
	assert property (@(posedge CLK) disable iff (!nRST || !`DCACHE_ASSERT_ON)
		!(match[0] && match[1]))
		else $error("dcacheWays: tag hit in both ways at index %0d", idx);

endmodule

`default_nettype wire

//--- dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Data word width, also the byte address width
`define DCACHE_WORD_BITS 32

// Address split: tag | index | block offset | byte offset
`define DCACHE_TAG_BITS 26
`define DCACHE_IDX_BITS 3

// Sets per way
`define DCACHE_SETS 8

// Address step between the two words of a block
`define DCACHE_WORD_BYTES 4

// Set to 0 to disable the embedded assertions
`define DCACHE_ASSERT_ON 1

`endif
